/* source/fight_pkg.sv */
package fight_pkg;

  localparam int POS_W   = 10;
  localparam int CNT_W   = 5;
  localparam int METER_W = 3;

  typedef enum logic [3:0] {
    IDLE,
    FWD,
    BACK,
    B_START,
    B_ACTIVE,
    B_RECOVER,
    D_START,
    D_ACTIVE,
    D_RECOVER,
    HITSTUN,
    BLOCKSTUN
  } fstate_t;

  typedef enum logic [1:0] {
    HIT_NONE,
    HIT_BASIC,
    HIT_DIR
  } hit_t;

  typedef enum logic [1:0] {
    PH_PREFIGHT,
    PH_FIGHT,
    PH_KO
  } phase_t;

  // Playfield in pixels
  localparam logic [POS_W-1:0] POS_Y         = 10'd170;
  localparam logic [POS_W-1:0] START_X_LEFT  = 10'd100;
  localparam logic [POS_W-1:0] START_X_RIGHT = 10'd427;
  localparam logic [POS_W-1:0] X_MIN         = 10'd10;
  localparam logic [POS_W-1:0] X_MAX         = 10'd517;
  localparam logic [POS_W-1:0] SPEED_FWD     = 10'd3;
  localparam logic [POS_W-1:0] SPEED_BACK    = 10'd2;
  localparam logic [POS_W-1:0] MIN_GAP       = 10'd30;
  localparam logic [POS_W-1:0] SPRITE_W      = 10'd113;

  // Unmirrored box offsets from the sprite origin
  localparam logic [POS_W-1:0] BASIC_X1 = 10'd35;
  localparam logic [POS_W-1:0] BASIC_X2 = 10'd113;
  localparam logic [POS_W-1:0] BASIC_Y1 = 10'd24;
  localparam logic [POS_W-1:0] BASIC_Y2 = 10'd57;
  localparam logic [POS_W-1:0] DIR_X1   = 10'd62;
  localparam logic [POS_W-1:0] DIR_X2   = 10'd95;
  localparam logic [POS_W-1:0] DIR_Y1   = 10'd6;
  localparam logic [POS_W-1:0] DIR_Y2   = 10'd110;
  localparam logic [POS_W-1:0] HURT_X1  = 10'd28;
  localparam logic [POS_W-1:0] HURT_X2  = 10'd81;
  localparam logic [POS_W-1:0] HURT_Y1  = 10'd0;
  localparam logic [POS_W-1:0] HURT_Y2  = 10'd150;

  // Extra frames spent in each timed state
  localparam logic [CNT_W-1:0] B_START_LEN     = 5'd5;
  localparam logic [CNT_W-1:0] B_ACTIVE_LEN    = 5'd2;
  localparam logic [CNT_W-1:0] B_RECOVER_LEN   = 5'd16;
  localparam logic [CNT_W-1:0] D_START_LEN     = 5'd4;
  localparam logic [CNT_W-1:0] D_ACTIVE_LEN    = 5'd3;
  localparam logic [CNT_W-1:0] D_RECOVER_LEN   = 5'd15;
  localparam logic [CNT_W-1:0] HITSTUN_BASIC   = 5'd15;
  localparam logic [CNT_W-1:0] HITSTUN_DIR     = 5'd14;
  localparam logic [CNT_W-1:0] BLOCKSTUN_BASIC = 5'd13;
  localparam logic [CNT_W-1:0] BLOCKSTUN_DIR   = 5'd12;

  localparam logic [METER_W-1:0] HEALTH_INIT = 3'd5;
  localparam logic [METER_W-1:0] GUARD_INIT  = 3'd3;
  localparam logic [METER_W-1:0] DMG_BASIC   = 3'd1;
  localparam logic [METER_W-1:0] DMG_DIR     = 3'd2;

endpackage

/* source/fighter_if.sv */
`timescale 1ns/100ps

interface fighter_if import fight_pkg::*; ();

  logic [POS_W-1:0] posx;
  fstate_t          state;
  logic [POS_W-1:0] hit_basic_x1, hit_basic_x2, hit_basic_y1, hit_basic_y2;
  logic [POS_W-1:0] hit_dir_x1, hit_dir_x2, hit_dir_y1, hit_dir_y2;
  logic [POS_W-1:0] hurt_x1, hurt_x2, hurt_y1, hurt_y2;
  // Set by the judge while an opponent's hit lands
  hit_t             hit;
  logic             guarded;

  modport fighter (
    output posx, state,
    output hit_basic_x1, hit_basic_x2, hit_basic_y1, hit_basic_y2,
    output hit_dir_x1, hit_dir_x2, hit_dir_y1, hit_dir_y2,
    output hurt_x1, hurt_x2, hurt_y1, hurt_y2,
    input  hit, guarded
  );

  modport judge (
    input  posx, state,
    input  hit_basic_x1, hit_basic_x2, hit_basic_y1, hit_basic_y2,
    input  hit_dir_x1, hit_dir_x2, hit_dir_y1, hit_dir_y2,
    input  hurt_x1, hurt_x2, hurt_y1, hurt_y2,
    output hit, guarded
  );

endinterface

/* source/fighter.sv */
`timescale 1ns/100ps

module fighter import fight_pkg::*; #(
  parameter bit SIDE = 1'b0
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             left,
  input  logic             right,
  input  logic             attack,
  input  logic             fight_active,
  input  logic [POS_W-1:0] other_posx,
  fighter_if.fighter       fi
);

  fstate_t          state_nxt;
  fstate_t          move_state;
  fstate_t          resume_state;
  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] stun_len;
  logic [CNT_W-1:0] stun_nxt;
  logic             load_stun;
  logic             in_stun;
  logic             step_up;
  logic             step_en;
  logic [POS_W-1:0] step_amt;
  logic [POS_W-1:0] posx_nxt;

  // Box edges; the right side mirrors the offsets across the sprite
  function automatic logic [POS_W-1:0] box_lo(input logic [POS_W-1:0] x,
                                              input logic [POS_W-1:0] lo,
                                              input logic [POS_W-1:0] hi);
    return SIDE ? x + SPRITE_W - hi : x + lo;
  endfunction

  function automatic logic [POS_W-1:0] box_hi(input logic [POS_W-1:0] x,
                                              input logic [POS_W-1:0] lo,
                                              input logic [POS_W-1:0] hi);
    return SIDE ? x + SPRITE_W - lo : x + hi;
  endfunction

  assign in_stun = (fi.state == HITSTUN) || (fi.state == BLOCKSTUN);

  // Forward is toward the opponent
  always_comb begin
    if (left && right) move_state = BACK;
    else if (left) move_state = SIDE ? FWD : BACK;
    else if (right) move_state = SIDE ? BACK : FWD;
    else move_state = IDLE;
  end

  assign resume_state = attack ? B_START : move_state;

  always_comb begin
    state_nxt = fi.state;
    load_stun = 1'b0;
    case (fi.hit)
      HIT_DIR: stun_nxt = fi.guarded ? BLOCKSTUN_DIR : HITSTUN_DIR;
      default: stun_nxt = fi.guarded ? BLOCKSTUN_BASIC : HITSTUN_BASIC;
    endcase

    if (!fight_active) begin
      state_nxt = IDLE;
    end else if (fi.hit != HIT_NONE && !in_stun) begin
      load_stun = 1'b1;
      state_nxt = fi.guarded ? BLOCKSTUN : HITSTUN;
    end else begin
      case (fi.state)
        IDLE: state_nxt = resume_state;
        FWD, BACK: state_nxt = attack ? D_START : move_state;
        B_START: if (cnt >= B_START_LEN) state_nxt = B_ACTIVE;
        B_ACTIVE: if (cnt >= B_ACTIVE_LEN) state_nxt = B_RECOVER;
        B_RECOVER: if (cnt >= B_RECOVER_LEN) state_nxt = resume_state;
        D_START: if (cnt >= D_START_LEN) state_nxt = D_ACTIVE;
        D_ACTIVE: if (cnt >= D_ACTIVE_LEN) state_nxt = D_RECOVER;
        D_RECOVER: if (cnt >= D_RECOVER_LEN) state_nxt = resume_state;
        HITSTUN, BLOCKSTUN: if (cnt >= stun_len) state_nxt = resume_state;
        default: state_nxt = IDLE;
      endcase
    end
  end

  // Frame counter restarts on each state change
  always_ff @(posedge clk) begin
    if (rst) begin
      fi.state <= IDLE;
      cnt      <= '0;
      stun_len <= '0;
    end else begin
      fi.state <= state_nxt;
      if (state_nxt != fi.state) cnt <= '0;
      else cnt <= cnt + 1'b1;
      if (load_stun) stun_len <= stun_nxt;
    end
  end

  always_comb begin
    step_up  = 1'b0;
    step_amt = SPEED_BACK;
    step_en  = 1'b0;
    case (fi.state)
      FWD: begin
        step_up  = !SIDE;
        step_amt = SPEED_FWD;
        // Hold off once inside the minimum gap
        step_en  = SIDE ? (fi.posx > other_posx + MIN_GAP)
                        : (fi.posx + MIN_GAP < other_posx);
      end
      BACK: begin
        step_up = SIDE;
        step_en = 1'b1;
      end
      default: begin
        step_en = 1'b0;
      end
    endcase

    if (step_up) posx_nxt = (fi.posx > X_MAX - step_amt) ? X_MAX : fi.posx + step_amt;
    else posx_nxt = (fi.posx < X_MIN + step_amt) ? X_MIN : fi.posx - step_amt;
  end

  always_ff @(posedge clk) begin
    if (rst) fi.posx <= SIDE ? START_X_RIGHT : START_X_LEFT;
    else if (fight_active && step_en) fi.posx <= posx_nxt;
  end

  always_ff @(posedge clk) begin
    fi.hit_basic_x1 <= box_lo(fi.posx, BASIC_X1, BASIC_X2);
    fi.hit_basic_x2 <= box_hi(fi.posx, BASIC_X1, BASIC_X2);
    fi.hit_basic_y1 <= POS_Y + BASIC_Y1;
    fi.hit_basic_y2 <= POS_Y + BASIC_Y2;
    fi.hit_dir_x1   <= box_lo(fi.posx, DIR_X1, DIR_X2);
    fi.hit_dir_x2   <= box_hi(fi.posx, DIR_X1, DIR_X2);
    fi.hit_dir_y1   <= POS_Y + DIR_Y1;
    fi.hit_dir_y2   <= POS_Y + DIR_Y2;
    fi.hurt_x1      <= box_lo(fi.posx, HURT_X1, HURT_X2);
    fi.hurt_x2      <= box_hi(fi.posx, HURT_X1, HURT_X2);
    fi.hurt_y1      <= POS_Y + HURT_Y1;
    fi.hurt_y2      <= POS_Y + HURT_Y2;
  end

  a_state_legal: assert property (
    @(posedge clk) disable iff (rst)
    !$isunknown(fi.state) && (fi.state <= BLOCKSTUN)
  );

endmodule

/* source/hit_judge.sv */
`timescale 1ns/100ps

module hit_judge import fight_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  fighter_if.judge           fl,
  fighter_if.judge           fr,
  input  logic [METER_W-1:0] guard_left,
  input  logic [METER_W-1:0] guard_right,
  output logic               dmg_left,
  output logic               dmg_right,
  output hit_t               dmg_kind_left,
  output hit_t               dmg_kind_right,
  output logic               guard_use_left,
  output logic               guard_use_right
);

  logic l_basic_on, l_dir_on, r_basic_on, r_dir_on;
  logic land_l, land_r;
  logic block_l, block_r;
  logic swing_l, swing_r;
  hit_t kind_l, kind_r;

  // Inclusive overlap on both axes
  function automatic logic overlap(
    input logic [POS_W-1:0] ax1, ax2, ay1, ay2,
    input logic [POS_W-1:0] bx1, bx2, by1, by2
  );
    return (ax1 <= bx2) && (bx1 <= ax2) && (ay1 <= by2) && (by1 <= ay2);
  endfunction

  // land_l means the left fighter's attack lands on the right one
  assign l_basic_on = (fl.state == B_ACTIVE) && overlap(
    fl.hit_basic_x1, fl.hit_basic_x2, fl.hit_basic_y1, fl.hit_basic_y2,
    fr.hurt_x1, fr.hurt_x2, fr.hurt_y1, fr.hurt_y2);
  assign l_dir_on = (fl.state == D_ACTIVE) && overlap(
    fl.hit_dir_x1, fl.hit_dir_x2, fl.hit_dir_y1, fl.hit_dir_y2,
    fr.hurt_x1, fr.hurt_x2, fr.hurt_y1, fr.hurt_y2);
  assign r_basic_on = (fr.state == B_ACTIVE) && overlap(
    fr.hit_basic_x1, fr.hit_basic_x2, fr.hit_basic_y1, fr.hit_basic_y2,
    fl.hurt_x1, fl.hurt_x2, fl.hurt_y1, fl.hurt_y2);
  assign r_dir_on = (fr.state == D_ACTIVE) && overlap(
    fr.hit_dir_x1, fr.hit_dir_x2, fr.hit_dir_y1, fr.hit_dir_y2,
    fl.hurt_x1, fl.hurt_x2, fl.hurt_y1, fl.hurt_y2);

  assign land_l = (l_basic_on || l_dir_on) && !swing_l;
  assign land_r = (r_basic_on || r_dir_on) && !swing_r;
  assign kind_l = l_dir_on ? HIT_DIR : HIT_BASIC;
  assign kind_r = r_dir_on ? HIT_DIR : HIT_BASIC;

  // Defender guards by walking back with guard left in the meter
  assign block_r = (fr.state == BACK) && (guard_right != '0);
  assign block_l = (fl.state == BACK) && (guard_left != '0);

  assign fr.hit     = land_l ? kind_l : HIT_NONE;
  assign fr.guarded = land_l && block_r;
  assign fl.hit     = land_r ? kind_r : HIT_NONE;
  assign fl.guarded = land_r && block_l;

  always_ff @(posedge clk) begin
    if (rst) begin
      swing_l         <= 1'b0;
      swing_r         <= 1'b0;
      dmg_left        <= 1'b0;
      dmg_right       <= 1'b0;
      dmg_kind_left   <= HIT_NONE;
      dmg_kind_right  <= HIT_NONE;
      guard_use_left  <= 1'b0;
      guard_use_right <= 1'b0;
    end else begin
      // Swing latch holds off a second hit until the active frames end
      swing_l         <= (fl.state == B_ACTIVE || fl.state == D_ACTIVE) && (swing_l || land_l);
      swing_r         <= (fr.state == B_ACTIVE || fr.state == D_ACTIVE) && (swing_r || land_r);
      dmg_right       <= land_l && !block_r;
      guard_use_right <= land_l && block_r;
      dmg_kind_right  <= land_l ? kind_l : HIT_NONE;
      dmg_left        <= land_r && !block_l;
      guard_use_left  <= land_r && block_l;
      dmg_kind_left   <= land_r ? kind_r : HIT_NONE;
    end
  end

  a_dmg_xor_guard: assert property (
    @(posedge clk) disable iff (rst)
    !(dmg_left && guard_use_left) && !(dmg_right && guard_use_right)
  );

endmodule

/* source/match_control.sv */
`timescale 1ns/100ps

module match_control import fight_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               dmg_left,
  input  logic               dmg_right,
  input  hit_t               dmg_kind_left,
  input  hit_t               dmg_kind_right,
  input  logic               guard_use_left,
  input  logic               guard_use_right,
  output phase_t             phase,
  output logic               fight_active,
  output logic [METER_W-1:0] health_left,
  output logic [METER_W-1:0] health_right,
  output logic [METER_W-1:0] guard_left,
  output logic [METER_W-1:0] guard_right,
  output logic               winner
);

  function automatic logic [METER_W-1:0] sat_sub(input logic [METER_W-1:0] a,
                                                 input logic [METER_W-1:0] b);
    return (a > b) ? a - b : '0;
  endfunction

  function automatic logic [METER_W-1:0] dmg_of(input hit_t kind);
    return (kind == HIT_DIR) ? DMG_DIR : DMG_BASIC;
  endfunction

  assign fight_active = (phase == PH_FIGHT);
  // Right wins only when left is out and right still stands
  assign winner = (health_left == '0) && (health_right != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      phase <= PH_PREFIGHT;
    end else begin
      case (phase)
        PH_PREFIGHT: if (start) phase <= PH_FIGHT;
        PH_FIGHT: if (health_left == '0 || health_right == '0) phase <= PH_KO;
        default: phase <= phase;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      health_left  <= HEALTH_INIT;
      health_right <= HEALTH_INIT;
      guard_left   <= GUARD_INIT;
      guard_right  <= GUARD_INIT;
    end else if (fight_active) begin
      if (dmg_left) health_left <= sat_sub(health_left, dmg_of(dmg_kind_left));
      if (dmg_right) health_right <= sat_sub(health_right, dmg_of(dmg_kind_right));
      if (guard_use_left) guard_left <= sat_sub(guard_left, 3'd1);
      if (guard_use_right) guard_right <= sat_sub(guard_right, 3'd1);
    end
  end

endmodule

/* source/fight_top.sv */
`timescale 1ns/100ps

module fight_top import fight_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               left_l,
  input  logic               right_l,
  input  logic               attack_l,
  input  logic               left_r,
  input  logic               right_r,
  input  logic               attack_r,
  output logic [POS_W-1:0]   posx_l,
  output logic [POS_W-1:0]   posx_r,
  output fstate_t            state_l,
  output fstate_t            state_r,
  output logic [METER_W-1:0] health_l,
  output logic [METER_W-1:0] health_r,
  output logic [METER_W-1:0] guard_l,
  output logic [METER_W-1:0] guard_r,
  output phase_t             phase,
  output logic               winner
);

  logic fight_active;
  logic dmg_left, dmg_right;
  logic guard_use_left, guard_use_right;
  hit_t dmg_kind_left, dmg_kind_right;

  fighter_if if_left ();
  fighter_if if_right ();

  fighter #(.SIDE(1'b0)) i_fighter_l (
    .clk          (clk),
    .rst          (rst),
    .left         (left_l),
    .right        (right_l),
    .attack       (attack_l),
    .fight_active (fight_active),
    .other_posx   (if_right.posx),
    .fi           (if_left)
  );

  fighter #(.SIDE(1'b1)) i_fighter_r (
    .clk          (clk),
    .rst          (rst),
    .left         (left_r),
    .right        (right_r),
    .attack       (attack_r),
    .fight_active (fight_active),
    .other_posx   (if_left.posx),
    .fi           (if_right)
  );

  hit_judge i_hit_judge (
    .clk             (clk),
    .rst             (rst),
    .fl              (if_left),
    .fr              (if_right),
    .guard_left      (guard_l),
    .guard_right     (guard_r),
    .dmg_left        (dmg_left),
    .dmg_right       (dmg_right),
    .dmg_kind_left   (dmg_kind_left),
    .dmg_kind_right  (dmg_kind_right),
    .guard_use_left  (guard_use_left),
    .guard_use_right (guard_use_right)
  );

  match_control i_match_control (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .dmg_left        (dmg_left),
    .dmg_right       (dmg_right),
    .dmg_kind_left   (dmg_kind_left),
    .dmg_kind_right  (dmg_kind_right),
    .guard_use_left  (guard_use_left),
    .guard_use_right (guard_use_right),
    .phase           (phase),
    .fight_active    (fight_active),
    .health_left     (health_l),
    .health_right    (health_r),
    .guard_left      (guard_l),
    .guard_right     (guard_r),
    .winner          (winner)
  );

  assign posx_l  = if_left.posx;
  assign posx_r  = if_right.posx;
  assign state_l = if_left.state;
  assign state_r = if_right.state;

endmodule

/* dv/fight_tb.sv */
`timescale 1ns/100ps

module fight_tb import fight_pkg::*; ();

  // Cycle budget per test; the run is cut off at twice their sum
  localparam int T_START = 50;
  localparam int T_MOVE  = 250;
  localparam int T_BASIC = 250;
  localparam int T_GUARD = 250;
  localparam int T_KO    = 200;
  localparam int LIMIT   = 2 * (T_START + T_MOVE + T_BASIC + T_GUARD + T_KO);

  logic               clk;
  logic               rst;
  logic               start;
  logic               left_l, right_l, attack_l;
  logic               left_r, right_r, attack_r;
  logic [POS_W-1:0]   posx_l, posx_r;
  fstate_t            state_l, state_r;
  logic [METER_W-1:0] health_l, health_r;
  logic [METER_W-1:0] guard_l, guard_r;
  phase_t             phase;
  logic               winner;

  int                 errors;
  int                 tests_run;
  int                 tests_failed;
  int                 cycles;
  int                 drops;
  int                 run_l [16];
  int                 run_r [16];
  fstate_t            seq_l [$];
  // Reference model of the left fighter and the right fighter's meters
  fstate_t            exp_st;
  logic [POS_W-1:0]   exp_pos;
  logic [POS_W-1:0]   exp_r;
  logic [METER_W-1:0] exp_health;
  logic [METER_W-1:0] exp_guard;

  fight_top i_fight_top (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run went past %0d cycles without finishing", LIMIT);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic check(input int got, input int want, input string what);
    if (got != want) begin
      errors++;
      $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, what, got, want);
    end
  endtask

  task automatic report_test(input string name, input int e0);
    tests_run++;
    if (errors == e0) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check errors", name, errors - e0);
    end
  endtask

  task automatic release_buttons();
    left_l   = 1'b0;
    right_l  = 1'b0;
    attack_l = 1'b0;
    left_r   = 1'b0;
    right_r  = 1'b0;
    attack_r = 1'b0;
  endtask

  task automatic apply_reset();
    rst   = 1'b1;
    start = 1'b0;
    release_buttons();
    repeat (16) @(negedge clk);
    rst        = 1'b0;
    exp_st     = IDLE;
    exp_pos    = START_X_LEFT;
    exp_r      = START_X_RIGHT;
    exp_health = HEALTH_INIT;
    exp_guard  = GUARD_INIT;
  endtask

  task automatic begin_fight();
    start = 1'b1;
    @(negedge clk);
    start = 0;
  endtask

  function automatic bit busy(input fstate_t s);
    return !(s == IDLE || s == FWD || s == BACK);
  endfunction

  // Position moves at the edge where the registered state is FWD or BACK
  task automatic walk_left(input bit l, input bit r, input int n);
    left_l  = l;
    right_l = r;
    repeat (n) begin
      @(negedge clk);
      if (exp_st == FWD && exp_pos + MIN_GAP < exp_r)
        exp_pos = exp_pos + SPEED_FWD;
      else if (exp_st == BACK)
        exp_pos = (exp_pos < X_MIN + SPEED_BACK) ? X_MIN : exp_pos - SPEED_BACK;
      exp_st = l ? BACK : (r ? FWD : IDLE);
      check(int'(state_l), int'(exp_st), "state_l");
      check(int'(posx_l), int'(exp_pos), "posx_l");
    end
  endtask

  task automatic close_gap();
    release_buttons();
    right_l = 1'b1;
    @(negedge clk);
    while (posx_r - posx_l > MIN_GAP) @(negedge clk);
    right_l = 1'b0;
    @(negedge clk);
  endtask

  // Left attacks once; state counts are kept until both sides are neutral
  task automatic left_swing();
    logic [METER_W-1:0] prev_h;
    foreach (run_l[i]) run_l[i] = 0;
    foreach (run_r[i]) run_r[i] = 0;
    seq_l.delete();
    drops = 0;
    prev_h = health_r;
    attack_l = 1'b1;
    @(negedge clk);
    attack_l = 1'b0;
    while (busy(state_l) || busy(state_r)) begin
      run_l[state_l]++;
      run_r[state_r]++;
      if (seq_l.size() == 0 || seq_l[$] != state_l) seq_l.push_back(state_l);
      if (health_r != prev_h) drops++;
      prev_h = health_r;
      @(negedge clk);
    end
    if (seq_l.size() == 0 || seq_l[$] != state_l) seq_l.push_back(state_l);
  endtask

  task automatic expect_order(input fstate_t s0, s1, s2, s3);
    fstate_t want [4];
    want = '{s0, s1, s2, s3};
    check(seq_l.size(), 4, "attacker state count");
    for (int i = 0; i < 4 && i < seq_l.size(); i++)
      check(int'(seq_l[i]), int'(want[i]), "attacker state order");
  endtask

  task automatic reset_then_start();
    int e0;
    e0 = errors;
    apply_reset();
    check(int'(posx_l), 100, "posx_l after reset");
    check(int'(posx_r), 427, "posx_r after reset");
    check(int'(state_l), int'(IDLE), "state_l after reset");
    check(int'(state_r), int'(IDLE), "state_r after reset");
    check(int'(health_l), 5, "health_l after reset");
    check(int'(health_r), 5, "health_r after reset");
    check(int'(guard_l), 3, "guard_l after reset");
    check(int'(guard_r), 3, "guard_r after reset");
    check(int'(phase), int'(PH_PREFIGHT), "phase after reset");
    right_l  = 1'b1;
    left_r   = 1'b1;
    attack_l = 1'b1;
    attack_r = 1'b1;
    repeat (4) @(negedge clk);
    check(int'(state_l), int'(IDLE), "state_l before start");
    check(int'(state_r), int'(IDLE), "state_r before start");
    check(int'(posx_l), 100, "posx_l before start");
    check(int'(posx_r), 427, "posx_r before start");
    release_buttons();
    begin_fight();
    check(int'(phase), int'(PH_FIGHT), "phase after start");
    report_test("reset_then_start", e0);
  endtask

  task automatic walk_limits();
    int e0;
    e0 = errors;
    walk_left(1'b1, 1'b1, 5);
    walk_left(1'b1, 1'b0, 50);
    check(int'(posx_l), 10, "posx_l at left limit");
    walk_left(1'b0, 1'b1, 140);
    check(int'(posx_r - posx_l <= MIN_GAP), 1, "gap after forward walk");
    walk_left(1'b0, 1'b0, 1);
    report_test("walk_limits", e0);
  endtask

  task automatic basic_hit();
    int e0;
    e0 = errors;
    apply_reset();
    begin_fight();
    left_swing();
    check(drops, 0, "health drops on whiff");
    check(run_r[HITSTUN], 0, "defender hitstun cycles on whiff");
    check(int'(health_r), int'(exp_health), "health_r after whiff");
    close_gap();
    left_swing();
    exp_health = exp_health - DMG_BASIC;
    expect_order(B_START, B_ACTIVE, B_RECOVER, IDLE);
    check(run_l[B_START], int'(B_START_LEN) + 1, "B_START cycles");
    check(run_l[B_ACTIVE], int'(B_ACTIVE_LEN) + 1, "B_ACTIVE cycles");
    check(run_l[B_RECOVER], int'(B_RECOVER_LEN) + 1, "B_RECOVER cycles");
    check(run_r[HITSTUN], int'(HITSTUN_BASIC) + 1, "defender hitstun cycles");
    check(drops, 1, "health drops on hit");
    check(int'(health_r), int'(exp_health), "health_r after hit");
    report_test("basic_hit", e0);
  endtask

  task automatic guard_and_break();
    int e0;
    e0 = errors;
    // Right holds back while left swings from a forward walk
    repeat (int'(GUARD_INIT) + 1) begin
      right_l = 1'b1;
      right_r = 1'b1;
      @(negedge clk);
      left_swing();
      expect_order(D_START, D_ACTIVE, D_RECOVER, FWD);
      check(run_l[D_ACTIVE], int'(D_ACTIVE_LEN) + 1, "D_ACTIVE cycles");
      if (exp_guard != 3'd0) begin
        exp_guard = exp_guard - 3'd1;
        check(run_r[BLOCKSTUN], int'(BLOCKSTUN_DIR) + 1, "defender blockstun cycles");
        check(run_r[HITSTUN], 0, "defender hitstun cycles on guard");
      end else begin
        exp_health = exp_health - DMG_DIR;
        check(run_r[HITSTUN], int'(HITSTUN_DIR) + 1, "defender hitstun cycles");
        check(run_r[BLOCKSTUN], 0, "defender blockstun cycles on empty guard");
      end
      check(int'(guard_r), int'(exp_guard), "guard_r");
      check(int'(health_r), int'(exp_health), "health_r");
      close_gap();
    end
    report_test("guard_and_break", e0);
  endtask

  task automatic knockout_lock();
    int               e0;
    logic [POS_W-1:0] px_l;
    logic [POS_W-1:0] px_r;
    e0 = errors;
    close_gap();
    while (exp_health != 3'd0) begin
      left_swing();
      exp_health = exp_health - DMG_BASIC;
      check(int'(health_r), int'(exp_health), "health_r on the way to knockout");
    end
    check(int'(phase), int'(PH_KO), "phase after knockout");
    check(int'(winner), 0, "winner");
    check(int'(health_l), 5, "health_l of the winner");
    px_l = posx_l;
    px_r = posx_r;
    right_l  = 1'b1;
    left_r   = 1'b1;
    attack_l = 1'b1;
    attack_r = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check(int'(state_l), int'(IDLE), "state_l after knockout");
      check(int'(state_r), int'(IDLE), "state_r after knockout");
      check(int'(posx_l), int'(px_l), "posx_l after knockout");
      check(int'(posx_r), int'(px_r), "posx_r after knockout");
    end
    release_buttons();
    check(int'(phase), int'(PH_KO), "phase held in knockout");
    report_test("knockout_lock", e0);
  endtask

  initial begin
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    reset_then_start();
    walk_limits();
    basic_hit();
    guard_and_break();
    knockout_lock();
    $display("Summary: %0d tests run, %0d failed, %0d check errors",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* fight.f */
source/fight_pkg.sv
source/fighter_if.sv
source/fighter.sv
source/hit_judge.sv
source/match_control.sv
source/fight_top.sv
dv/fight_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fight testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fight_tb -f fight.f

out=$(./obj_dir/Vfight_tb)
echo "$out"
echo "$out" | grep -q "^=== PASS ===$"
